// ==== include/loopFilter_consts.svh ====
`ifndef LOOPFILTER_CONSTS_SVH
`define LOOPFILTER_CONSTS_SVH

// Register address map, 12-bit byte addresses with exact-match decode.
`define LF_ADDR_W    12
`define LF_CONTROL   12'h000
`define LF_LEAD_LAG  12'h004
`define LF_LIMIT     12'h008
`define LF_LOOPDATA  12'h00C

// Datapath and bus widths.
`define LF_ERR_W     16
`define LF_WORD_W    32
`define LF_BYTES     4    // Byte lanes per bus word.

// Gain field widths.
`define LF_MAN_W     8
`define LF_EXP_W     5

`endif

// ==== design/lfRegPkg.sv ====
`include "loopFilter_consts.svh"

package lfRegPkg;

    // Control register, only the low three bits are stored.
    typedef struct packed {
        logic [`LF_WORD_W-4:0] pad;
        logic                  hold;         // Freezes integration.
        logic                  invertError;
        logic                  zeroError;
    } lfControl_t;

    // Lead and lag gains in mantissa/exponent form.
    typedef struct packed {
        logic [`LF_MAN_W-1:0] leadMan;
        logic [2:0]           pad2;
        logic [`LF_EXP_W-1:0] leadExp;
        logic [`LF_MAN_W-1:0] lagMan;
        logic [2:0]           pad0;
        logic [`LF_EXP_W-1:0] lagExp;
    } lfGains_t;

    // One bus word, decoded by address as control or gains.
    typedef union packed {
        logic [`LF_WORD_W-1:0] raw;
        lfControl_t            ctrl;
        lfGains_t              gains;
    } lfRegWord_u;

endpackage

// ==== design/lfLoopPkg.sv ====
`include "loopFilter_consts.svh"

package lfLoopPkg;

    // Conditioned error sample.
    typedef struct packed {
        logic                        valid;
        logic signed [`LF_ERR_W-1:0] value;
    } loopSample_t;

    // Output of a gain stage.
    typedef struct packed {
        logic                         valid;
        logic signed [`LF_WORD_W-1:0] value;
    } loopTerm_t;

    // Integrator preload request from the bus.
    typedef struct packed {
        logic [`LF_BYTES-1:0]  byteEn;
        logic [`LF_WORD_W-1:0] data;
    } loopLoad_t;

endpackage

// ==== design/loopRegs.sv ====
`include "loopFilter_consts.svh"

module loopRegs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`LF_ADDR_W-1:0]     addr,
    input  logic [`LF_WORD_W-1:0]     dataIn,
    input  logic                      cs,
    input  logic [`LF_BYTES-1:0]      wr,
    output logic [`LF_WORD_W-1:0]     dataOut,
    input  logic [`LF_WORD_W-1:0]     integValue,
    output lfRegPkg::lfControl_t      control,
    output lfRegPkg::lfGains_t        gains,
    output logic [`LF_WORD_W-1:0]     limit,
    output lfLoopPkg::loopLoad_t      load
);
    import lfRegPkg::*;

    lfRegWord_u wrWord;
    lfRegWord_u rdWord;

    assign wrWord.raw = dataIn;

    always_ff @(posedge clk) begin
        if (reset) begin
            control <= '0;
            gains   <= '0;
            limit   <= '0;
        end else if (cs) begin
            case (addr)
                `LF_CONTROL: begin
                    if (wr[0]) begin
                        control.zeroError   <= wrWord.ctrl.zeroError;
                        control.invertError <= wrWord.ctrl.invertError;
                        control.hold        <= wrWord.ctrl.hold;
                    end
                end
                `LF_LEAD_LAG: begin
                    if (wr[0]) gains.lagExp  <= wrWord.gains.lagExp;
                    if (wr[1]) gains.lagMan  <= wrWord.gains.lagMan;
                    if (wr[2]) gains.leadExp <= wrWord.gains.leadExp;
                    if (wr[3]) gains.leadMan <= wrWord.gains.leadMan;
                end
                `LF_LIMIT: begin
                    for (int i = 0; i < `LF_BYTES; i++) begin
                        if (wr[i]) limit[8*i +: 8] <= dataIn[8*i +: 8];
                    end
                end
                default: ;  // Loop data goes to the integrator.
            endcase
        end
    end

    // Loop data writes become byte preloads of the integrator.
    always_comb begin
        load.data   = dataIn;
        load.byteEn = (cs && addr == `LF_LOOPDATA) ? wr : '0;
    end

    always_comb begin
        rdWord.raw = '0;
        if (cs) begin
            case (addr)
                `LF_CONTROL: begin
                    rdWord.ctrl.zeroError   = control.zeroError;
                    rdWord.ctrl.invertError = control.invertError;
                    rdWord.ctrl.hold        = control.hold;
                end
                `LF_LEAD_LAG: begin
                    rdWord.gains.lagExp  = gains.lagExp;
                    rdWord.gains.lagMan  = gains.lagMan;
                    rdWord.gains.leadExp = gains.leadExp;
                    rdWord.gains.leadMan = gains.leadMan;
                end
                `LF_LIMIT:    rdWord.raw = limit;
                `LF_LOOPDATA: rdWord.raw = integValue;  // Live integrator.
                default: ;
            endcase
        end
    end

    assign dataOut = rdWord.raw;

    addrKnownOnWrite: assert property (
        @(posedge clk) disable iff (reset)
        (cs && |wr) |-> !$isunknown(addr)
    );

endmodule

// ==== design/loopCtrl.sv ====
`include "loopFilter_consts.svh"

module loopCtrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic signed [`LF_ERR_W-1:0] error,
    input  logic                        errorValid,
    input  lfRegPkg::lfControl_t        control,
    output lfLoopPkg::loopSample_t      sample,
    output logic                        accumulateEn
);

    logic signed [`LF_ERR_W-1:0] condError;

    always_comb begin
        if (control.zeroError) begin
            condError = '0;
        end else if (control.invertError) begin
            condError = -error;  // Wraps for the most negative code.
        end else begin
            condError = error;
        end
    end

    always_ff @(posedge clk) begin
        sample.value <= condError;
    end

    // The hold bit is taken at the gain stage edge, so it stays with its terms.
    always_ff @(posedge clk) begin
        if (reset) begin
            sample.valid <= 1'b0;
            accumulateEn <= 1'b0;
        end else begin
            sample.valid <= errorValid;
            accumulateEn <= sample.valid && !control.hold;
        end
    end

endmodule

// ==== design/loopGain.sv ====
`include "loopFilter_consts.svh"

module loopGain (
    input  logic                   clk,
    input  logic                   reset,
    input  lfLoopPkg::loopSample_t sample,
    input  logic [`LF_MAN_W-1:0]   mantissa,
    input  logic [`LF_EXP_W-1:0]   exponent,
    output lfLoopPkg::loopTerm_t   term
);

    logic signed [`LF_ERR_W+`LF_MAN_W:0] product;
    logic signed [`LF_WORD_W-1:0]        scaled;

    always_comb begin
        product = sample.value * $signed({1'b0, mantissa});  // Mantissa is a magnitude.
        scaled  = `LF_WORD_W'(product) <<< exponent;          // Low word kept, wraps.
    end

    always_ff @(posedge clk) begin
        term.value <= scaled;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            term.valid <= 1'b0;
        end else begin
            term.valid <= sample.valid;
        end
    end

    validOneCycle: assert property (
        @(posedge clk) disable iff (reset)
        term.valid == $past(sample.valid)
    );

endmodule

// ==== design/loopIntegrator.sv ====
`include "loopFilter_consts.svh"

module loopIntegrator (
    input  logic                         clk,
    input  logic                         reset,
    input  lfLoopPkg::loopTerm_t         leadTerm,
    input  lfLoopPkg::loopTerm_t         lagTerm,
    input  logic                         accumulateEn,
    input  logic [`LF_WORD_W-1:0]        limit,
    input  lfLoopPkg::loopLoad_t         load,
    output logic [`LF_WORD_W-1:0]        integValue,
    output logic signed [`LF_WORD_W-1:0] loopOut,
    output logic                         outValid
);

    logic signed [`LF_WORD_W-1:0] integ;
    logic signed [`LF_WORD_W-1:0] accumValue;
    logic signed [`LF_WORD_W-1:0] nextInteg;
    logic signed [`LF_WORD_W:0]   sum;       // One guard bit for the clamp.
    logic signed [`LF_WORD_W:0]   posLimit;
    logic signed [`LF_WORD_W:0]   negLimit;
    logic signed [`LF_WORD_W:0]   integWide;

    always_comb begin
        posLimit   = {2'b00, limit[`LF_WORD_W-2:0]};
        negLimit   = -posLimit;
        sum        = {integ[`LF_WORD_W-1], integ} +
                     {lagTerm.value[`LF_WORD_W-1], lagTerm.value};
        accumValue = integ;
        if (accumulateEn) begin
            if (sum > posLimit) accumValue = posLimit[`LF_WORD_W-1:0];
            else if (sum < negLimit) accumValue = negLimit[`LF_WORD_W-1:0];
            else accumValue = sum[`LF_WORD_W-1:0];
        end
        nextInteg = accumValue;
        for (int i = 0; i < `LF_BYTES; i++) begin
            if (load.byteEn[i]) nextInteg[8*i +: 8] = load.data[8*i +: 8];  // Preload wins.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            integ    <= '0;
            loopOut  <= '0;
            outValid <= 1'b0;
        end else begin
            integ    <= nextInteg;
            outValid <= leadTerm.valid;
            if (leadTerm.valid) loopOut <= leadTerm.value + nextInteg;  // Wraps at 32 bits.
        end
    end

    assign integValue = integ;
    assign integWide  = {integ[`LF_WORD_W-1], integ};

    integWithinLimit: assert property (
        @(posedge clk) disable iff (reset)
        (accumulateEn && load.byteEn == '0) |=>
            (integWide <= $past(posLimit)) && (integWide >= $past(negLimit))
    );

endmodule

// ==== design/loopFilter.sv ====
`include "loopFilter_consts.svh"

module loopFilter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`LF_ADDR_W-1:0]        addr,
    input  logic [`LF_WORD_W-1:0]        dataIn,
    input  logic                         cs,
    input  logic [`LF_BYTES-1:0]         wr,
    output logic [`LF_WORD_W-1:0]        dataOut,
    input  logic signed [`LF_ERR_W-1:0]  error,
    input  logic                         errorValid,
    output logic signed [`LF_WORD_W-1:0] loopOut,
    output logic                         outValid
);
    import lfRegPkg::*;
    import lfLoopPkg::*;

    lfControl_t            control;
    lfGains_t              gains;
    logic [`LF_WORD_W-1:0] limit;
    logic [`LF_WORD_W-1:0] integValue;
    loopLoad_t             load;
    loopSample_t           sample;
    loopTerm_t             leadTerm;
    loopTerm_t             lagTerm;
    logic                  accumulateEn;

    loopRegs loopRegs_i (
        .clk(clk), .reset(reset), .addr(addr), .dataIn(dataIn), .cs(cs), .wr(wr),
        .dataOut(dataOut), .integValue(integValue), .control(control), .gains(gains),
        .limit(limit), .load(load)
    );

    loopCtrl loopCtrl_i (
        .clk(clk), .reset(reset), .error(error), .errorValid(errorValid),
        .control(control), .sample(sample), .accumulateEn(accumulateEn)
    );

    loopGain leadGain_i (
        .clk(clk), .reset(reset), .sample(sample), .mantissa(gains.leadMan),
        .exponent(gains.leadExp), .term(leadTerm)
    );

    loopGain lagGain_i (
        .clk(clk), .reset(reset), .sample(sample), .mantissa(gains.lagMan),
        .exponent(gains.lagExp), .term(lagTerm)
    );

    loopIntegrator loopIntegrator_i (
        .clk(clk), .reset(reset), .leadTerm(leadTerm), .lagTerm(lagTerm),
        .accumulateEn(accumulateEn), .limit(limit), .load(load),
        .integValue(integValue), .loopOut(loopOut), .outValid(outValid)
    );

endmodule

// ==== testbench/loopFilterTb.sv ====
`include "loopFilter_consts.svh"

module loopFilterTb;
    timeunit 1ns;
    timeprecision 100ps;
    import lfRegPkg::*;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_IDLE, OP_SAMPLE} op_e;

    typedef struct packed {
        op_e                         op;
        logic [`LF_ADDR_W-1:0]       addr;
        logic [`LF_BYTES-1:0]        wr;
        logic [`LF_WORD_W-1:0]       data;
        logic signed [`LF_ERR_W-1:0] err;
        logic [`LF_WORD_W-1:0]       expected;  // Read entries only.
    } stimEntry_t;

    logic                         clk;
    logic                         reset;
    logic [`LF_ADDR_W-1:0]        addr;
    logic [`LF_WORD_W-1:0]        dataIn;
    logic                         cs;
    logic [`LF_BYTES-1:0]         wr;
    logic [`LF_WORD_W-1:0]        dataOut;
    logic signed [`LF_ERR_W-1:0]  error;
    logic                         errorValid;
    logic signed [`LF_WORD_W-1:0] loopOut;
    logic                         outValid;

    stimEntry_t            stimTable[$];
    int                    expectQ[$];  // loopOut values still in flight.
    lfRegWord_u            mCtrl;       // Reference model registers.
    lfRegWord_u            mGains;
    logic [`LF_WORD_W-1:0] mLimit;
    int                    mInteg;
    int                    mismatches;
    int                    failures;

    loopFilter loopFilter_i (
        .clk(clk), .reset(reset), .addr(addr), .dataIn(dataIn), .cs(cs), .wr(wr),
        .dataOut(dataOut), .error(error), .errorValid(errorValid),
        .loopOut(loopOut), .outValid(outValid)
    );

    always #50 clk = ~clk;

    task checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // Signed product, shifted, low word kept.
    function automatic int gainTerm(input shortint e, input logic [7:0] man,
                                    input logic [4:0] ex);
        longint prod;
        prod = longint'(e) * longint'(man);
        prod = prod << ex;
        return int'(prod[31:0]);
    endfunction

    function automatic int modelStep(input shortint e);
        shortint c;
        int      lead;
        int      lag;
        longint  sum;
        longint  lim;
        c = e;
        if (mCtrl.ctrl.zeroError) c = 0;
        else if (mCtrl.ctrl.invertError) c = -e;
        lead = gainTerm(c, mGains.gains.leadMan, mGains.gains.leadExp);
        lag  = gainTerm(c, mGains.gains.lagMan, mGains.gains.lagExp);
        if (!mCtrl.ctrl.hold) begin
            lim = longint'(mLimit[30:0]);
            sum = longint'(mInteg) + longint'(lag);
            if (sum > lim) sum = lim;
            else if (sum < -lim) sum = -lim;
            mInteg = int'(sum[31:0]);
        end
        return lead + mInteg;
    endfunction

    function automatic void modelWrite(input logic [11:0] a, input logic [3:0] w,
                                       input logic [31:0] d);
        logic [31:0] lanes;
        for (int i = 0; i < 4; i++) lanes[8*i +: 8] = {8{w[i]}};
        case (a)
            `LF_CONTROL:  mCtrl.raw  = (mCtrl.raw & ~lanes) | (d & lanes & 32'h0000_0007);
            `LF_LEAD_LAG: mGains.raw = (mGains.raw & ~lanes) | (d & lanes & 32'hFF1F_FF1F);
            `LF_LIMIT:    mLimit     = (mLimit & ~lanes) | (d & lanes);
            `LF_LOOPDATA: mInteg     = (mInteg & ~lanes) | (d & lanes);
            default: ;
        endcase
    endfunction

    task writeReg(input logic [11:0] a, input logic [3:0] w, input logic [31:0] d);
        addr   = a;
        dataIn = d;
        wr     = w;
        cs     = 1'b1;
        @(posedge clk);
        #5;
        cs = 1'b0;
        wr = '0;
        modelWrite(a, w, d);
    endtask

    task readReg(input logic [11:0] a, input logic sel, output logic [31:0] v);
        addr = a;
        cs   = sel;
        wr   = '0;
        #20 v = dataOut;  // Combinational read, settled well before the edge.
        @(posedge clk);
        #5;
        cs = 1'b0;
    endtask

    task runSample(input shortint e);
        int expOut;
        int lat;
        expOut     = modelStep(e);
        error      = e;
        errorValid = 1'b1;
        @(posedge clk);
        #5;
        errorValid = 1'b0;
        lat        = 0;
        while (!outValid && lat < 8) begin
            @(posedge clk);
            #5;
            lat++;
        end
        if (!outValid) begin
            $display("Error at %0t ns: outValid never came for error %0d", $time, e);
            failures++;
        end else begin
            checkValue("outValid latency", lat, 2);
            checkValue("loopOut", loopOut, expOut);
        end
    endtask

    task checkOutput();
        if (outValid) begin
            if (expectQ.size() == 0) begin
                $display("Error at %0t ns: outValid came with no sample in flight", $time);
                failures++;
            end else begin
                checkValue("loopOut", loopOut, expectQ.pop_front());
            end
        end
    endtask

    // Back-to-back samples, two in flight at a time.
    task randomBurst(input int count);
        shortint e;
        int      idle;
        for (int k = 0; k < count; k++) begin
            checkOutput();
            e          = shortint'($urandom);
            error      = e;
            errorValid = 1'b1;
            expectQ.push_back(modelStep(e));
            @(posedge clk);
            #5;
        end
        errorValid = 1'b0;
        idle       = 0;
        while (expectQ.size() > 0 && idle < 8) begin
            checkOutput();
            @(posedge clk);
            #5;
            idle++;
        end
        if (expectQ.size() > 0) begin
            $display("Error at %0t ns: outValid never came for %0d samples", $time,
                     expectQ.size());
            failures++;
            expectQ.delete();
        end
    endtask

    task addEntry(input op_e op, input logic [11:0] a, input logic [3:0] w,
                  input logic [31:0] d, input shortint e, input logic [31:0] x);
        stimTable.push_back('{op, a, w, d, e, x});
    endtask

    task buildTable();
        addEntry(OP_WRITE,  `LF_CONTROL,  4'hF, 32'hFFFF_FFFF, 0, 0);
        addEntry(OP_READ,   `LF_CONTROL,  4'h0, 0, 0, 32'h0000_0007);
        addEntry(OP_WRITE,  `LF_CONTROL,  4'hE, 32'h0000_0000, 0, 0);
        addEntry(OP_READ,   `LF_CONTROL,  4'h0, 0, 0, 32'h0000_0007);
        addEntry(OP_WRITE,  `LF_CONTROL,  4'h1, 32'h0000_0000, 0, 0);
        addEntry(OP_READ,   `LF_CONTROL,  4'h0, 0, 0, 32'h0000_0000);
        addEntry(OP_WRITE,  `LF_LEAD_LAG, 4'hF, 32'hFFFF_FFFF, 0, 0);
        addEntry(OP_READ,   `LF_LEAD_LAG, 4'h0, 0, 0, 32'hFF1F_FF1F);
        addEntry(OP_WRITE,  `LF_LEAD_LAG, 4'h5, 32'h0000_0000, 0, 0);
        addEntry(OP_READ,   `LF_LEAD_LAG, 4'h0, 0, 0, 32'hFF00_FF00);
        addEntry(OP_WRITE,  `LF_LIMIT,    4'h3, 32'h1234_5678, 0, 0);
        addEntry(OP_WRITE,  `LF_LIMIT,    4'hC, 32'hABCD_0000, 0, 0);
        addEntry(OP_READ,   `LF_LIMIT,    4'h0, 0, 0, 32'hABCD_5678);
        addEntry(OP_WRITE,  12'h010,      4'hF, 32'hFFFF_FFFF, 0, 0);
        addEntry(OP_READ,   12'h010,      4'h0, 0, 0, 32'h0000_0000);
        addEntry(OP_IDLE,   `LF_LIMIT,    4'h0, 0, 0, 32'h0000_0000);
        addEntry(OP_WRITE,  `LF_LEAD_LAG, 4'hF, 32'h0302_0000, 0, 0);  // Lead only.
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 100, 0);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, -50, 0);
        addEntry(OP_WRITE,  `LF_LIMIT,    4'hF, 32'h0000_03E8, 0, 0);
        addEntry(OP_WRITE,  `LF_LEAD_LAG, 4'hF, 32'h0000_0501, 0, 0);  // Lag only.
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 40, 0);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 40, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'h0000_0320);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 40, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'h0000_03E8);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, -100, 0);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, -100, 0);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, -100, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'hFFFF_FC18);
        addEntry(OP_WRITE,  `LF_LEAD_LAG, 4'hF, 32'h0200_0100, 0, 0);
        addEntry(OP_WRITE,  `LF_CONTROL,  4'h1, 32'h0000_0001, 0, 0);  // zeroError.
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 77, 0);
        addEntry(OP_WRITE,  `LF_CONTROL,  4'h1, 32'h0000_0002, 0, 0);  // invertError.
        addEntry(OP_SAMPLE, 0, 4'h0, 0, -30, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'hFFFF_FC36);
        addEntry(OP_WRITE,  `LF_CONTROL,  4'h1, 32'h0000_0004, 0, 0);  // hold.
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 50, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'hFFFF_FC36);
        addEntry(OP_WRITE,  `LF_LOOPDATA, 4'h1, 32'h0000_0064, 0, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'hFFFF_FC64);
        addEntry(OP_WRITE,  `LF_LOOPDATA, 4'hE, 32'h0000_0000, 0, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'h0000_0064);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 10, 0);
        addEntry(OP_WRITE,  `LF_CONTROL,  4'h1, 32'h0000_0000, 0, 0);
        addEntry(OP_SAMPLE, 0, 4'h0, 0, 10, 0);
        addEntry(OP_READ,   `LF_LOOPDATA, 4'h0, 0, 0, 32'h0000_006E);
    endtask

    initial begin
        stimEntry_t  ent;
        logic [31:0] got;
        void'($urandom(69));
        clk        = 1'b0;
        reset      = 1'b1;
        addr       = '0;
        dataIn     = '0;
        cs         = 1'b0;
        wr         = '0;
        error      = '0;
        errorValid = 1'b0;
        mCtrl.raw  = '0;
        mGains.raw = '0;
        mLimit     = '0;
        mInteg     = 0;
        mismatches = 0;
        failures   = 0;
        buildTable();
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        foreach (stimTable[i]) begin
            ent = stimTable[i];
            case (ent.op)
                OP_WRITE: writeReg(ent.addr, ent.wr, ent.data);
                OP_READ: begin
                    readReg(ent.addr, 1'b1, got);
                    checkValue($sformatf("dataOut[%h]", ent.addr), got, ent.expected);
                end
                OP_IDLE: begin
                    readReg(ent.addr, 1'b0, got);
                    checkValue("dataOut with cs low", got, ent.expected);
                end
                default: runSample(ent.err);
            endcase
        end
        for (int r = 0; r < 4; r++) begin
            writeReg(`LF_CONTROL, 4'hF, $urandom_range(0, 7));
            writeReg(`LF_LEAD_LAG, 4'hF, $urandom);
            writeReg(`LF_LIMIT, 4'hF, $urandom);
            randomBurst(16);
        end
        $display("Run complete: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== loopFilter.f ====
+incdir+include
design/lfRegPkg.sv
design/lfLoopPkg.sv
design/loopRegs.sv
design/loopCtrl.sv
design/loopGain.sv
design/loopIntegrator.sv
design/loopFilter.sv
testbench/loopFilterTb.sv
